/* hw/relax_config.svh */
`ifndef RELAX_CONFIG_SVH
`define RELAX_CONFIG_SVH

////////////////////////////////////////////////////////////
// engine sizing
////////////////////////////////////////////////////////////

// node count, power of two
`define RELAX_NODES 16

// edge table slots, power of two
`define RELAX_EDGES 32

// distance width, all ones reserved for unreachable
`define RELAX_DIST_W 16

// edge weight width, unsigned
`define RELAX_WEIGHT_W 8

`endif

/* hw/relax_pkg.sv */
`include "relax_config.svh"

package relax_pkg;

    ////////////////////////////////////////////////////////////
    // index and value types
    ////////////////////////////////////////////////////////////

    // node index
    typedef logic [$clog2(`RELAX_NODES)-1:0] node_t;

    // edge slot index
    typedef logic [$clog2(`RELAX_EDGES)-1:0] edge_idx_t;

    // unsigned distance
    typedef logic [`RELAX_DIST_W-1:0] dist_t;

    // unreachable marker, all ones
    localparam dist_t dist_inf = '1;

    // one edge table entry, valid bit lives in edge_scan
    typedef struct packed {
        node_t                     src;
        node_t                     dst;
        logic [`RELAX_WEIGHT_W-1:0] weight;
    } edge_t;

    ////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////

    // encodings 110 and 111 are illegal
    typedef enum logic [2:0] {
        IDLE       = 3'b000,
        GET_PARAM  = 3'b001,
        GET_DATA   = 3'b010,
        EX         = 3'b011,
        WRITE_BACK = 3'b100,
        DONE       = 3'b101
    } seq_state_t;

endpackage

/* hw/sync_ram.sv */
`timescale 1ns/10ps

module sync_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr_a,
    input  logic [$clog2(depth)-1:0] raddr_b,
    output payload_t                 rdata_a,
    output payload_t                 rdata_b
);

    // storage array
    payload_t mem [depth];

    // single write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // two registered read ports
    // same-address write in the same cycle gives old contents
    always_ff @(posedge clk) begin
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

/* hw/state_control.sv */
`timescale 1ns/10ps

module state_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  is_start,
    input  logic                  is_find,
    input  logic                  is_finish,
    output relax_pkg::seq_state_t state
);

    import relax_pkg::*;

    ////////////////////////////////////////////////////////////
    // pass sequencer
    ////////////////////////////////////////////////////////////

    // one edge in flight
    // GET_PARAM -> GET_DATA -> EX -> WRITE_BACK -> GET_PARAM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (is_finish && state != IDLE) begin
            // nothing left to visit, end the pass
            state <= DONE;
        end else begin
            case (state)
                IDLE: begin
                    // wait for the host request
                    if (is_start) begin
                        state <= GET_PARAM;
                    end else begin
                        state <= IDLE;
                    end
                end
                GET_PARAM: begin
                    // edge_scan reports the next unfinished edge
                    if (is_find) begin
                        state <= GET_DATA;
                    end else begin
                        state <= GET_PARAM;
                    end
                end
                GET_DATA: begin
                    // edge entry registered, distance reads issued
                    state <= EX;
                end
                EX: begin
                    // relax decision latched
                    state <= WRITE_BACK;
                end
                WRITE_BACK: begin
                    // back for the next edge
                    state <= GET_PARAM;
                end
                DONE: begin
                    // done_ack stays up until the host drops start_req
                    if (!is_start) begin
                        state <= IDLE;
                    end else begin
                        state <= DONE;
                    end
                end
                default: begin
                    // illegal encoding holds
                    state <= state;
                end
            endcase
        end
    end

endmodule

/* hw/edge_scan.sv */
`timescale 1ns/10ps
`include "relax_config.svh"

module edge_scan (
    input  logic                  clk,
    input  logic                  rst_n,
    input  relax_pkg::seq_state_t state,
    input  logic                  load_edge_en,
    input  relax_pkg::edge_idx_t  load_addr,
    input  logic                  load_valid,
    input  logic                  edge_done,
    input  relax_pkg::edge_idx_t  done_idx,
    output logic                  is_find,
    output logic                  is_finish,
    output relax_pkg::edge_idx_t  cur_edge
);

    import relax_pkg::*;

    // per-slot flags
    logic [`RELAX_EDGES-1:0] valid_vec;
    logic [`RELAX_EDGES-1:0] finished_vec;
    // valid and not yet visited this pass
    logic [`RELAX_EDGES-1:0] pending;

    ////////////////////////////////////////////////////////////
    // flag registers
    ////////////////////////////////////////////////////////////

    // valid bits come from host loads only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_vec <= '0;
        end else if (load_edge_en) begin
            valid_vec[load_addr] <= load_valid;
        end
    end

    // finished bits
    // held clear while idle, so a pass starts with a clean vector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            finished_vec <= '0;
        end else if (state == IDLE) begin
            finished_vec <= '0;
        end else if (edge_done) begin
            finished_vec[done_idx] <= 1'b1;
        end
    end

    assign pending = valid_vec & ~finished_vec;

    ////////////////////////////////////////////////////////////
    // lowest-index search
    ////////////////////////////////////////////////////////////

    // scan downward so the lowest pending slot wins
    always_comb begin
        is_find  = 1'b0;
        cur_edge = '0;
        for (int i = `RELAX_EDGES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                is_find  = 1'b1;
                cur_edge = edge_idx_t'(i);
            end
        end
    end

    // out of work while a pass is running
    assign is_finish = !is_find && (state != IDLE) && (state != DONE);

endmodule

/* hw/relax_exec.sv */
`timescale 1ns/10ps

module relax_exec (
    input  logic                  clk,
    input  logic                  rst_n,
    input  relax_pkg::seq_state_t state,
    input  relax_pkg::edge_t      cur,
    input  relax_pkg::dist_t      src_dist,
    input  relax_pkg::dist_t      dst_dist,
    output relax_pkg::dist_t      new_dist,
    output logic                  do_relax
);

    import relax_pkg::*;

    // distance width
    localparam int dw = $bits(dist_t);

    // one extra bit catches the carry
    logic [dw:0] wide_sum;
    dist_t       sat_sum;
    logic        relax_now;

    ////////////////////////////////////////////////////////////
    // saturating add and compare
    ////////////////////////////////////////////////////////////

    always_comb begin
        wide_sum = (dw + 1)'(src_dist) + (dw + 1)'(cur.weight);
        // overflow clamps to unreachable
        if (wide_sum[dw]) begin
            sat_sum = dist_inf;
        end else begin
            sat_sum = wide_sum[dw-1:0];
        end
        // unreachable source never relaxes
        // a clamped sum can never compare below dst_dist
        relax_now = (src_dist != dist_inf) && (sat_sum < dst_dist);
    end

    // decision, held through WRITE_BACK
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            do_relax <= 1'b0;
        end else if (state == EX) begin
            do_relax <= relax_now;
        end
    end

    // candidate distance
    always_ff @(posedge clk) begin
        if (state == EX) begin
            new_dist <= sat_sum;
        end
    end

endmodule

/* hw/dist_writeback.sv */
`timescale 1ns/10ps
`include "relax_config.svh"

module dist_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  relax_pkg::seq_state_t state,
    input  logic                  do_relax,
    input  relax_pkg::dist_t      new_dist,
    input  relax_pkg::edge_idx_t  cur_edge,
    input  relax_pkg::node_t      dst,
    output logic                  dist_we,
    output relax_pkg::node_t      dist_waddr,
    output relax_pkg::dist_t      dist_wdata,
    output logic                  edge_done,
    output relax_pkg::edge_idx_t  done_idx,
    output logic [`RELAX_EDGES:0] relax_count
);

    import relax_pkg::*;

    // state was IDLE last cycle
    logic was_idle;

    ////////////////////////////////////////////////////////////
    // write port and finish pulse
    ////////////////////////////////////////////////////////////

    // one-cycle pulse per visited edge
    assign edge_done  = (state == WRITE_BACK);
    assign done_idx   = cur_edge;

    // only improving edges touch the distance table
    assign dist_we    = edge_done && do_relax;
    assign dist_waddr = dst;
    assign dist_wdata = new_dist;

    // pass start is IDLE followed by GET_PARAM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            was_idle <= 1'b1;
        end else begin
            was_idle <= (state == IDLE);
        end
    end

    // improvement counter, kept after the pass for the host
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            relax_count <= '0;
        end else if (was_idle && state == GET_PARAM) begin
            relax_count <= '0;
        end else if (dist_we) begin
            relax_count <= relax_count + 1'b1;
        end
    end

endmodule

/* hw/relax_top.sv */
`timescale 1ns/10ps
`include "relax_config.svh"

module relax_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_req,
    output logic                  done_ack,
    output logic                  busy,
    input  logic                  load_edge_en,
    input  logic                  load_dist_en,
    input  relax_pkg::edge_idx_t  load_addr,
    input  relax_pkg::edge_t      load_edge,
    input  logic                  load_valid,
    input  relax_pkg::dist_t      load_dist,
    input  relax_pkg::node_t      rd_addr,
    output relax_pkg::dist_t      rd_data,
    output logic [`RELAX_EDGES:0] relax_count
);

    import relax_pkg::*;

    // sequencer and scan
    seq_state_t state;
    logic       is_find;
    logic       is_finish;
    edge_idx_t  cur_edge;
    // edge table outputs
    edge_t      cur;
    edge_t      wb_edge;
    // distance table ports
    dist_t      src_dist;
    dist_t      dst_dist;
    logic       dist_we;
    node_t      dist_waddr;
    dist_t      dist_wdata;
    node_t      dist_raddr_a;
    // stage results
    dist_t      new_dist;
    logic       do_relax;
    logic       wb_we;
    node_t      wb_waddr;
    dist_t      wb_wdata;
    logic       edge_done;
    edge_idx_t  done_idx;
    // host loads accepted only while idle
    logic       edge_load_ok;
    logic       dist_load_ok;

    ////////////////////////////////////////////////////////////
    // handshake and host gating
    ////////////////////////////////////////////////////////////

    assign done_ack     = (state == DONE);
    assign busy         = (state != IDLE) && (state != DONE);
    assign edge_load_ok = load_edge_en && !busy;
    assign dist_load_ok = load_dist_en && !busy;

    // writeback owns the distance write port during a pass
    assign dist_we      = busy ? wb_we    : dist_load_ok;
    assign dist_waddr   = busy ? wb_waddr : node_t'(load_addr);
    assign dist_wdata   = busy ? wb_wdata : load_dist;
    // port a serves host readout while idle
    assign dist_raddr_a = busy ? cur.src  : rd_addr;
    assign rd_data      = src_dist;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    state_control u_ctrl (
        .clk(clk), .rst_n(rst_n), .is_start(start_req),
        .is_find(is_find), .is_finish(is_finish), .state(state)
    );

    edge_scan u_scan (
        .clk(clk), .rst_n(rst_n), .state(state),
        .load_edge_en(edge_load_ok), .load_addr(load_addr), .load_valid(load_valid),
        .edge_done(edge_done), .done_idx(done_idx),
        .is_find(is_find), .is_finish(is_finish), .cur_edge(cur_edge)
    );

    // port b carries the same entry to writeback for its dst
    sync_ram #(.payload_t(edge_t), .depth(`RELAX_EDGES)) u_edge_ram (
        .clk(clk), .we(edge_load_ok), .waddr(load_addr), .wdata(load_edge),
        .raddr_a(cur_edge), .raddr_b(cur_edge), .rdata_a(cur), .rdata_b(wb_edge)
    );

    sync_ram #(.payload_t(dist_t), .depth(`RELAX_NODES)) u_dist_ram (
        .clk(clk), .we(dist_we), .waddr(dist_waddr), .wdata(dist_wdata),
        .raddr_a(dist_raddr_a), .raddr_b(cur.dst), .rdata_a(src_dist), .rdata_b(dst_dist)
    );

    relax_exec u_exec (
        .clk(clk), .rst_n(rst_n), .state(state), .cur(cur),
        .src_dist(src_dist), .dst_dist(dst_dist), .new_dist(new_dist), .do_relax(do_relax)
    );

    dist_writeback u_wb (
        .clk(clk), .rst_n(rst_n), .state(state), .do_relax(do_relax),
        .new_dist(new_dist), .cur_edge(cur_edge), .dst(wb_edge.dst),
        .dist_we(wb_we), .dist_waddr(wb_waddr), .dist_wdata(wb_wdata),
        .edge_done(edge_done), .done_idx(done_idx), .relax_count(relax_count)
    );

endmodule

/* bench/relax_checker.sv */
`timescale 1ns/10ps

module relax_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       start_req,
    input logic       done_ack,
    input logic [2:0] state
);

    import relax_pkg::*;

    ////////////////////////////////////////////////////////////
    // host handshake
    ////////////////////////////////////////////////////////////

    // new request only once done_ack is back low
    a_start_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start_req) |-> !done_ack)
        else $error("start_req rose while done_ack was high");

    // DONE is left only after the host drops start_req
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(done_ack) |-> !$past(start_req))
        else $error("done_ack fell with start_req still high");

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    // 110 and 111 never reached
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, GET_PARAM, GET_DATA, EX, WRITE_BACK, DONE})
        else $error("sequencer in an illegal state %b", state);

endmodule

bind relax_top relax_checker u_checker (
    .clk(clk), .rst_n(rst_n), .start_req(start_req),
    .done_ack(done_ack), .state(state)
);

/* bench/relax_tb.sv */
`timescale 1ns/10ps
`include "relax_config.svh"

module relax_tb;

    import relax_pkg::*;

    localparam int clk_period     = 4;
    // longest pass: every slot valid, plus the closing GET_PARAM
    localparam int pass_cycles    = 4 * `RELAX_EDGES + 1;
    // empty pass, 16 on the random graph, two directed
    localparam int planned_passes = 19;
    localparam int watchdog_ns    = 8 * pass_cycles * planned_passes * clk_period;

    logic                  clk;
    logic                  rst_n;
    logic                  start_req;
    logic                  done_ack;
    logic                  busy;
    logic                  load_edge_en;
    logic                  load_dist_en;
    edge_idx_t             load_addr;
    edge_t                 load_edge;
    logic                  load_valid;
    dist_t                 load_dist;
    node_t                 rd_addr;
    dist_t                 rd_data;
    logic [`RELAX_EDGES:0] relax_count;

    // host-side copy of both tables
    edge_t sh_edge [`RELAX_EDGES];
    logic  sh_valid [`RELAX_EDGES];
    dist_t sh_dist [`RELAX_NODES];

    logic [15:0] lfsr;
    int          err_value;
    int          err_other;
    int          last_count;

    relax_top UUT (
        .clk(clk), .rst_n(rst_n), .start_req(start_req), .done_ack(done_ack), .busy(busy),
        .load_edge_en(load_edge_en), .load_dist_en(load_dist_en), .load_addr(load_addr),
        .load_edge(load_edge), .load_valid(load_valid), .load_dist(load_dist),
        .rd_addr(rd_addr), .rd_data(rd_data), .relax_count(relax_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, a pass never completed", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic edge_t make_edge(input int s, input int d, input int w);
        edge_t e;
        e.src    = node_t'(s);
        e.dst    = node_t'(d);
        e.weight = w[`RELAX_WEIGHT_W-1:0];
        return e;
    endfunction

    function automatic int count_valid();
        int k;
        k = 0;
        for (int i = 0; i < `RELAX_EDGES; i++) begin
            if (sh_valid[i]) begin
                k++;
            end
        end
        return k;
    endfunction

    // one pass in slot order over the shadow tables
    // updates sh_dist, returns the improvement count
    function automatic int ref_pass();
        int                     cnt;
        dist_t                  s;
        logic [`RELAX_DIST_W:0] wide;
        dist_t                  sum;
        cnt = 0;
        for (int i = 0; i < `RELAX_EDGES; i++) begin
            if (sh_valid[i]) begin
                s    = sh_dist[sh_edge[i].src];
                wide = {1'b0, s} + {{(`RELAX_DIST_W + 1 - `RELAX_WEIGHT_W){1'b0}},
                                    sh_edge[i].weight};
                // saturate past the top of the range
                sum  = (wide > {1'b0, dist_inf}) ? dist_inf : wide[`RELAX_DIST_W-1:0];
                if (s != dist_inf && sum < sh_dist[sh_edge[i].dst]) begin
                    sh_dist[sh_edge[i].dst] = sum;
                    cnt++;
                end
            end
        end
        return cnt;
    endfunction

    ////////////////////////////////////////////////////////////
    // host access tasks
    ////////////////////////////////////////////////////////////

    task automatic load_edge_slot(input int slot, input edge_t e, input logic v);
        @(negedge clk);
        load_edge_en   = 1'b1;
        load_addr      = edge_idx_t'(slot);
        load_edge      = e;
        load_valid     = v;
        @(negedge clk);
        load_edge_en   = 1'b0;
        sh_edge[slot]  = e;
        sh_valid[slot] = v;
    endtask

    task automatic load_dist_node(input int n, input dist_t d);
        @(negedge clk);
        load_dist_en = 1'b1;
        load_addr    = edge_idx_t'(n);
        load_dist    = d;
        @(negedge clk);
        load_dist_en = 1'b0;
        sh_dist[n]   = d;
    endtask

    // source node 0 at zero, the rest unreachable
    task automatic init_dists();
        for (int n = 0; n < `RELAX_NODES; n++) begin
            load_dist_node(n, (n == 0) ? dist_t'(0) : dist_inf);
        end
    endtask

    task automatic clear_edges();
        for (int i = 0; i < `RELAX_EDGES; i++) begin
            load_edge_slot(i, '0, 1'b0);
        end
    endtask

    task automatic build_random_graph();
        edge_t       e;
        logic [31:0] r;
        logic        v;
        for (int i = 0; i < `RELAX_EDGES; i++) begin
            e.src    = node_t'(rand_bits($bits(node_t)));
            e.dst    = node_t'(rand_bits($bits(node_t)));
            r        = rand_bits(`RELAX_WEIGHT_W);
            e.weight = r[`RELAX_WEIGHT_W-1:0];
            // no zero weights, so a stray write of 0 shows up
            if (e.weight == 0) begin
                e.weight = 1;
            end
            // about three slots in four, slot 0 always
            v = (rand_bits(2) != 0) || (i == 0);
            load_edge_slot(i, e, v);
        end
        init_dists();
    endtask

    // data one cycle after the address
    task automatic read_node(input int n, output dist_t d);
        @(negedge clk);
        rd_addr = node_t'(n);
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic expect_node(input int n, input dist_t exp);
        dist_t d;
        read_node(n, d);
        if (d !== exp) begin
            $display("Error: rd_data node %0d expected %h got %h", n, exp, d);
            err_value++;
        end
    endtask

    task automatic check_distances();
        for (int n = 0; n < `RELAX_NODES; n++) begin
            expect_node(n, sh_dist[n]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one pass with full handshake
    ////////////////////////////////////////////////////////////

    task automatic run_pass(input logic intrude);
        int   n;
        int   exp_k;
        int   exp_cnt;
        logic done_seen;
        exp_k     = count_valid();
        exp_cnt   = ref_pass();
        n         = 0;
        done_seen = 1'b0;
        @(negedge clk);
        start_req = 1'b1;
        // t0, start sampled in IDLE
        @(posedge clk);
        while (!done_seen && n <= pass_cycles) begin
            @(negedge clk);
            if (n == 0 && !busy) begin
                $display("busy stayed low after the start request was taken");
                err_other++;
            end
            if (intrude && n == 0) begin
                // host traffic while busy, must bounce
                load_edge_en = 1'b1;
                load_dist_en = 1'b1;
                load_addr    = edge_idx_t'(`RELAX_EDGES - 1);
                load_edge    = make_edge(0, 1, 0);
                load_valid   = 1'b1;
                load_dist    = '0;
                rd_addr      = node_t'(5);
            end else if (intrude && n == 1) begin
                load_edge_en = 1'b0;
                load_dist_en = 1'b0;
            end
            if (done_ack) begin
                done_seen = 1'b1;
            end else begin
                n++;
            end
        end
        if (!done_seen) begin
            $display("done_ack never rose within %0d cycles of the start", pass_cycles + 1);
            err_other++;
        end else if (n != 4 * exp_k + 1) begin
            $display("Error: done_ack latency expected %h got %h", 4 * exp_k + 1, n);
            err_value++;
        end
        last_count = int'(relax_count);
        if ($isunknown(relax_count) || last_count != exp_cnt) begin
            $display("Error: relax_count expected %h got %h", exp_cnt, relax_count);
            err_value++;
        end
        // start_req held, engine parks in DONE
        repeat (3) begin
            @(negedge clk);
            if (!done_ack) begin
                $display("done_ack dropped while start_req was still high");
                err_other++;
            end
        end
        start_req = 1'b0;
        @(negedge clk);
        if (done_ack || busy) begin
            $display("engine did not return to idle after start_req fell");
            err_other++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr         = 16'd45908;
        err_value    = 0;
        err_other    = 0;
        last_count   = 0;
        rst_n        = 1'b0;
        start_req    = 1'b0;
        load_edge_en = 1'b0;
        load_dist_en = 1'b0;
        load_addr    = '0;
        load_edge    = '0;
        load_valid   = 1'b0;
        load_dist    = '0;
        rd_addr      = '0;
        for (int i = 0; i < `RELAX_EDGES; i++) begin
            sh_edge[i]  = '0;
            sh_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (done_ack || busy) begin
            $display("done_ack or busy high right after reset");
            err_other++;
        end

        // empty edge table, done one cycle after t0
        run_pass(1'b0);

        // random graph, first pass with host traffic while busy
        build_random_graph();
        run_pass(1'b1);
        check_distances();
        for (int p = 1; p < `RELAX_NODES - 1; p++) begin
            run_pass(1'b0);
            check_distances();
        end
        // shortest paths settled, nothing left to improve
        run_pass(1'b0);
        if (last_count != 0) begin
            $display("Error: relax_count expected %h got %h", 0, last_count);
            err_value++;
        end
        check_distances();

        // invalid slot 6 would have reached node 2
        clear_edges();
        init_dists();
        load_edge_slot(5, make_edge(0, 1, 3), 1'b1);
        load_edge_slot(6, make_edge(0, 2, 1), 1'b0);
        load_edge_slot(9, make_edge(1, 3, 2), 1'b1);
        run_pass(1'b0);
        check_distances();
        expect_node(1, 3);
        expect_node(2, dist_inf);
        expect_node(3, 5);

        // unreachable source, overflow, plain relax, sum landing on inf
        clear_edges();
        init_dists();
        load_dist_node(4, 100);
        load_dist_node(5, dist_inf - 15);
        load_dist_node(6, dist_inf - 1);
        load_dist_node(7, dist_inf - 255);
        load_dist_node(9, dist_inf - 15);
        load_edge_slot(0, make_edge(3, 4, 1), 1'b1);
        load_edge_slot(1, make_edge(5, 6, 32), 1'b1);
        load_edge_slot(2, make_edge(7, 8, 16), 1'b1);
        load_edge_slot(3, make_edge(9, 10, 15), 1'b1);
        run_pass(1'b0);
        check_distances();
        expect_node(4, 100);
        expect_node(6, dist_inf - 1);
        expect_node(8, dist_inf - 239);
        expect_node(10, dist_inf);

        $display("summary: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/relax_pkg.sv
hw/sync_ram.sv
hw/state_control.sv
hw/edge_scan.sv
hw/relax_exec.sv
hw/dist_writeback.sv
hw/relax_top.sv
bench/relax_checker.sv
bench/relax_tb.sv

/* Makefile */
# Verilator build and run of the relaxation engine testbench

VERILATOR ?= verilator
TOP       ?= relax_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
